/* Makefile */
# Verilator build for the pseudo-LRU replacement block

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       := lruTopTb
FILELIST  := src.f
OBJDIR    := obj_dir
PASSMSG   := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# The run passes only when the pass message shows up in the output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASSMSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* hw/dualPortRam.sv */
/*
 * Two-port synchronous RAM.
 * Each port has one write and one registered read, with read-first behavior.
 */

`timescale 1ns/1ps
`default_nettype none

module dualPortRam
#(
    parameter int depth = 64,
    parameter int width = 4
)
(
    input  wire logic                     clk,

    // Port 0
    input  wire logic [$clog2(depth)-1:0] addr0,
    input  wire logic                     wen0,
    input  wire logic [width-1:0]         wdata0,
    output logic      [width-1:0]         rdata0,

    // Port 1
    input  wire logic [$clog2(depth)-1:0] addr1,
    input  wire logic                     wen1,
    input  wire logic [width-1:0]         wdata1,
    output logic      [width-1:0]         rdata1
);

    // Storage array, contents only defined after the owner clears it
    logic [width-1:0] mem [depth];

    // Both ports live in one block so the array has a single driver
    always_ff @(posedge clk)
    begin
        if (wen0)
        begin
            mem[addr0] <= wdata0;
        end
        if (wen1)
        begin
            mem[addr1] <= wdata1;
        end
        // Nonblocking reads see the value from before this cycle's writes
        rdata0 <= mem[addr0];
        rdata1 <= mem[addr1];
    end

endmodule

`default_nettype wire

/* hw/hitRecorder.sv */
/*
 * Hit front end of the replacement block.
 * Decodes hit strobes to one-hot way masks and merges runs of hits
 * to the same set into a single reference on update port 0.
 */

`timescale 1ns/1ps
`default_nettype none

module hitRecorder import lruPkg::*;
(
    input  wire logic   clk,
    input  wire logic   resetb,

    // Incoming hits, one per cycle at most
    input  wire logic   hitEn,
    input  wire setIdxT hitIdx,
    input  wire wayIdxT hitWay,

    // Merged references toward the store
    output setIdxT      refIdx,
    output wayVecT      refWayVec,
    output logic        refEn
);

    // One-hot form of the way that hit this cycle
    wayVecT hitVec;

    // The single pending entry
    logic   pendValid;
    setIdxT pendIdx;
    wayVecT pendVec;

    // High when this cycle's hit lands in the set that is being held
    logic   sameSet;

    always_comb
    begin
        hitVec = '0;
        hitVec[hitWay] = 1'b1;
    end

    assign sameSet = hitEn && pendValid && (hitIdx == pendIdx);

    // ====================
    // Pending entry
    // ====================

    // A hit is held one cycle, a same-set hit extends the hold
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            pendValid <= 1'b0;
        end
        else
        begin
            pendValid <= hitEn;
        end
    end

    // Payload merges on a same-set hit and is replaced otherwise
    always_ff @(posedge clk)
    begin
        if (hitEn)
        begin
            pendIdx <= hitIdx;
            pendVec <= sameSet ? (pendVec | hitVec) : hitVec;
        end
    end

    // The held entry leaves unless a same-set hit folds into it this cycle
    assign refEn     = pendValid && !sameSet;
    assign refIdx    = pendIdx;
    assign refWayVec = pendVec;

    // Every emitted reference must mark at least one way
    refNotEmpty: assert property (@(posedge clk) disable iff (!resetb)
        refEn |-> (refWayVec != '0));

endmodule

`default_nettype wire

/* hw/lruLookupIf.sv */
/*
 * Victim lookup bus between the miss handler and the LRU store.
 * A request carries a set index and the answer returns a cycle later.
 */

`timescale 1ns/1ps
`default_nettype none

interface lruLookupIf import lruPkg::*; ();

    // Request strobe and the set being asked about
    logic   en;
    setIdxT idx;

    // Answer in two forms, one-hot and binary, valid the cycle after en
    wayVecT vecRsp;
    wayIdxT rsp;

    // The side that asks for a victim
    modport requester
    (
        output en,
        output idx,
        input  vecRsp,
        input  rsp
    );

    // The side that holds the LRU bits and answers
    modport responder
    (
        input  en,
        input  idx,
        output vecRsp,
        output rsp
    );

endinterface

`default_nettype wire

/* hw/lruPkg.sv */
/*
 * Shared sizes and types for the pseudo-LRU replacement block.
 * Holds the way and set counts and the vector types built from them.
 */

`default_nettype none

package lruPkg;

    // ====================
    // Geometry
    // ====================

    // Ways per set in the cache being tracked
    localparam int nWays = 4;

    // Number of sets, small enough for a quick simulation sweep
    localparam int nSets = 64;

    // Bits needed to name one set or one way
    localparam int setIdxW = $clog2(nSets);
    localparam int wayIdxW = $clog2(nWays);

    // ====================
    // Vector types
    // ====================

    // Index of one set in the replacement store
    typedef logic [setIdxW-1:0] setIdxT;

    // Binary way number, as returned with a victim
    typedef logic [wayIdxW-1:0] wayIdxT;

    // One bit per way, used both as a reference mask and as one-hot victim
    typedef logic [nWays-1:0] wayVecT;

endpackage

`default_nettype wire

/* hw/lruTop.sv */
/*
 * Top level of the pseudo-LRU replacement block.
 * Connects the hit front end, the bit store and the miss handler.
 */

`timescale 1ns/1ps
`default_nettype none

module lruTop import lruPkg::*;
(
    input  wire logic   clk,
    input  wire logic   resetb,

    // Cache hits
    input  wire logic   hitEn,
    input  wire setIdxT hitIdx,
    input  wire wayIdxT hitWay,

    // Cache misses
    input  wire logic   missEn,
    input  wire setIdxT missIdx,

    // Status and victim
    output logic        rdy,
    output logic        victimValid,
    output wayIdxT      victimWay,
    output wayVecT      victimVec
);

    // Reference path from the hit front end
    setIdxT ref0Idx;
    wayVecT ref0Vec;
    logic   ref0En;

    // Reference path from the miss handler
    setIdxT ref1Idx;
    wayVecT ref1Vec;
    logic   ref1En;

    lruLookupIf lookupBus ();

    hitRecorder hitRec
    (
        .clk       (clk),
        .resetb    (resetb),
        .hitEn     (hitEn),
        .hitIdx    (hitIdx),
        .hitWay    (hitWay),
        .refIdx    (ref0Idx),
        .refWayVec (ref0Vec),
        .refEn     (ref0En)
    );

    pseudoLru lruStore
    (
        .clk        (clk),
        .resetb     (resetb),
        .rdy        (rdy),
        .lookup     (lookupBus.responder),
        .refIdx0    (ref0Idx),
        .refWayVec0 (ref0Vec),
        .refEn0     (ref0En),
        .refIdx1    (ref1Idx),
        .refWayVec1 (ref1Vec),
        .refEn1     (ref1En)
    );

    victimSelector victimSel
    (
        .clk         (clk),
        .resetb      (resetb),
        .rdy         (rdy),
        .missEn      (missEn),
        .missIdx     (missIdx),
        .lookup      (lookupBus.requester),
        .refIdx      (ref1Idx),
        .refWayVec   (ref1Vec),
        .refEn       (ref1En),
        .victimValid (victimValid),
        .victimWay   (victimWay),
        .victimVec   (victimVec)
    );

endmodule

`default_nettype wire

/* hw/pseudoLru.sv */
/*
 * Pseudo-LRU bit store, one bit per way for every set.
 * Clears the RAM with a sweep after reset, then runs two read-modify-write
 * update ports and one lookup port that returns the lowest clear way.
 */

`timescale 1ns/1ps
`default_nettype none

module pseudoLru import lruPkg::*;
(
    input  wire logic   clk,
    input  wire logic   resetb,

    // High once the sweep has cleared every set
    output logic        rdy,

    // Victim lookups, answered one cycle after the request
    lruLookupIf.responder lookup,

    // Reference port 0
    input  wire setIdxT refIdx0,
    input  wire wayVecT refWayVec0,
    input  wire logic   refEn0,

    // Reference port 1
    input  wire setIdxT refIdx1,
    input  wire wayVecT refWayVec1,
    input  wire logic   refEn1
);

    // Per-port update sequence: capture, read, then modify-write
    typedef enum logic [1:0] {updIdle, updRead, updWrite} updStateT;

    // OR in the new references and start over once every way is marked
    function automatic wayVecT updateBits(input wayVecT cur, input wayVecT add);
        wayVecT merged;
        merged = cur | add;
        return (&merged) ? wayVecT'('0) : merged;
    endfunction

    // ====================
    // Storage
    // ====================

    setIdxT addr0;
    logic   wen0;
    wayVecT wdata0;
    wayVecT rdata0;

    setIdxT addr1;
    logic   wen1;
    wayVecT wdata1;
    wayVecT rdata1;

    dualPortRam
    #(
        .depth (nSets),
        .width ($bits(wayVecT))
    )
    lruBits
    (
        .clk    (clk),
        .addr0  (addr0),
        .wen0   (wen0),
        .wdata0 (wdata0),
        .rdata0 (rdata0),
        .addr1  (addr1),
        .wen1   (wen1),
        .wdata1 (wdata1),
        .rdata1 (rdata1)
    );

    // ====================
    // Init sweep
    // ====================

    // One extra bit so the top bit marks the end of the sweep
    logic [setIdxW:0] initIdx;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            initIdx <= '0;
        end
        else if (!rdy)
        begin
            initIdx <= initIdx + 1'b1;
        end
    end

    assign rdy = initIdx[setIdxW];

    // ====================
    // Update engines
    // ====================

    // Both reference ports share the same sequence, indexed by port number
    setIdxT   refIdxArr [2];
    wayVecT   refVecArr [2];
    logic     refEnArr  [2];
    updStateT updState  [2];
    setIdxT   updIdx    [2];
    wayVecT   updVec    [2];

    assign refIdxArr[0] = refIdx0;
    assign refVecArr[0] = refWayVec0;
    assign refEnArr[0]  = refEn0;
    assign refIdxArr[1] = refIdx1;
    assign refVecArr[1] = refWayVec1;
    assign refEnArr[1]  = refEn1;

    // References are only taken in idle, the rest are lost on purpose
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            for (int p = 0; p < 2; p++)
            begin
                updState[p] <= updIdle;
            end
        end
        else
        begin
            for (int p = 0; p < 2; p++)
            begin
                case (updState[p])
                    updIdle:  updState[p] <= (refEnArr[p] && rdy) ? updRead : updIdle;
                    // Port 0 owns its RAM port, while a lookup takes port 1's read
                    // and a stolen read leaves nothing valid to modify
                    updRead:  updState[p] <= (p == 1 && lookup.en) ? updIdle : updWrite;
                    default:  updState[p] <= updIdle;
                endcase
            end
        end
    end

    // Captured reference, held through the read and the write
    always_ff @(posedge clk)
    begin
        for (int p = 0; p < 2; p++)
        begin
            if (updState[p] == updIdle)
            begin
                updIdx[p] <= refIdxArr[p];
                updVec[p] <= refVecArr[p];
            end
        end
    end

    // ====================
    // RAM port 0
    // ====================

    // The sweep writes zeros, afterwards the port follows update engine 0
    assign wen0   = !rdy || (updState[0] == updWrite);
    assign addr0  = rdy ? updIdx[0] : initIdx[setIdxW-1:0];
    assign wdata0 = rdy ? updateBits(rdata0, updVec[0]) : wayVecT'('0);

    // ====================
    // RAM port 1
    // ====================

    // Lookups win the port, and a write never collides with port 0's set
    assign addr1  = lookup.en ? lookup.idx : updIdx[1];
    assign wdata1 = updateBits(rdata1, updVec[1]);
    assign wen1   = (updState[1] == updWrite) && !lookup.en &&
                    !(wen0 && (addr0 == updIdx[1]));

    // Lowest clear way of the set read last cycle, in both forms
    always_comb
    begin
        lookup.vecRsp = '0;
        lookup.rsp    = '0;
        for (int w = nWays - 1; w >= 0; w--)
        begin
            if (!rdata1[w])
            begin
                lookup.vecRsp    = '0;
                lookup.vecRsp[w] = 1'b1;
                lookup.rsp       = wayIdxT'(w);
            end
        end
    end

    // The two RAM ports never write one set in the same cycle
    noDualWrite: assert property (@(posedge clk) disable iff (!resetb)
        !(wen0 && wen1 && (addr0 == addr1)));

    // A set is never left full, so every answer after the sweep names one way
    rspOneHot: assert property (@(posedge clk) disable iff (!resetb)
        (rdy && lookup.en) |=> $onehot(lookup.vecRsp));

endmodule

`default_nettype wire

/* hw/victimSelector.sv */
/*
 * Miss handler of the replacement block.
 * Issues a lookup on each miss, returns the victim a cycle later and
 * feeds it back to the store as a reference for the coming fill.
 */

`timescale 1ns/1ps
`default_nettype none

module victimSelector import lruPkg::*;
(
    input  wire logic   clk,
    input  wire logic   resetb,

    // Store is initialized and may be asked
    input  wire logic   rdy,

    // Incoming misses
    input  wire logic   missEn,
    input  wire setIdxT missIdx,

    // Lookup bus toward the store
    lruLookupIf.requester lookup,

    // Victim recorded as referenced on update port 1
    output setIdxT      refIdx,
    output wayVecT      refWayVec,
    output logic        refEn,

    // Chosen victim
    output logic        victimValid,
    output wayIdxT      victimWay,
    output wayVecT      victimVec
);

    // Set of the miss whose answer arrives this cycle
    setIdxT missSet;

    // Misses during the sweep are dropped here
    assign lookup.en  = missEn && rdy;
    assign lookup.idx = missIdx;

    // ====================
    // Response stage
    // ====================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            victimValid <= 1'b0;
        end
        else
        begin
            victimValid <= lookup.en;
        end
    end

    always_ff @(posedge clk)
    begin
        if (lookup.en)
        begin
            missSet <= missIdx;
        end
    end

    // The answer is only meaningful in the cycle after a lookup
    assign victimVec = victimValid ? lookup.vecRsp : wayVecT'('0);
    assign victimWay = victimValid ? lookup.rsp : wayIdxT'('0);

    // The line is about to be filled, so mark the victim as used
    assign refEn     = victimValid;
    assign refIdx    = missSet;
    assign refWayVec = victimVec;

    // Every victim names exactly one way
    victimOneHot: assert property (@(posedge clk) disable iff (!resetb)
        victimValid |-> $onehot(victimVec));

endmodule

`default_nettype wire

/* sim/lruTopTb.sv */
/*
 * Testbench for the pseudo-LRU replacement block.
 * Keeps a model of the bits of every set, drives spaced hits and misses,
 * and checks the DUT with concurrent assertions and a watchdog.
 */

`timescale 1ns/1ps
`default_nettype none

module lruTopTb import lruPkg::*; ();

    // ====================
    // Timing constants
    // ====================

    localparam int clkPeriod = 10;
    localparam int resetCycles = 2;

    // Idle cycles after each hit or miss so no update is ever dropped
    localparam int gapCycles = 6;

    // Random hit and miss pairs at the end of the run
    localparam int nRandom = 24;

    // Directed operations plus the random ones, each at most gap plus three cycles
    localparam int nOps = 24 + 2 * nRandom;
    localparam int watchdogCycles = resetCycles + nSets + nOps * (gapCycles + 3) + 200;

    // ====================
    // DUT signals
    // ====================

    logic   clk = 1'b0;
    logic   resetb;
    logic   hitEn;
    setIdxT hitIdx;
    wayIdxT hitWay;
    logic   missEn;
    setIdxT missIdx;
    logic   rdy;
    logic   victimValid;
    wayIdxT victimWay;
    wayVecT victimVec;

    // Model state and the victim predicted for the miss in flight
    wayVecT modelBits [nSets];
    wayIdxT expWay;
    wayVecT expVec;

    string  testName;
    integer seed = 32'h97f0_ae12;

    // Cycles since reset was released, saturating well past the sweep
    int     sinceRelease;

    lruTop UUT
    (
        .clk         (clk),
        .resetb      (resetb),
        .hitEn       (hitEn),
        .hitIdx      (hitIdx),
        .hitWay      (hitWay),
        .missEn      (missEn),
        .missIdx     (missIdx),
        .rdy         (rdy),
        .victimValid (victimValid),
        .victimWay   (victimWay),
        .victimVec   (victimVec)
    );

    always #(clkPeriod / 2) clk = ~clk;

    always @(posedge clk)
    begin
        if (!resetb)
        begin
            sinceRelease <= 0;
        end
        else if (sinceRelease < 2 * nSets)
        begin
            sinceRelease <= sinceRelease + 1;
        end
    end

    // ====================
    // Reporting and model
    // ====================

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic flagMismatch(input string what, input string expStr, input string actStr);
        reportFailure($sformatf("Mismatch in test %s, %s: expected %s, actual %s",
                                testName, what, expStr, actStr));
    endtask

    function automatic wayVecT oneHotOf(input wayIdxT way);
        wayVecT vec;
        vec = '0;
        vec[way] = 1'b1;
        return vec;
    endfunction

    // A set collects references until every way is marked, then starts empty
    function automatic wayVecT markWays(input wayVecT cur, input wayVecT add);
        wayVecT next;
        next = cur | add;
        if (next == {nWays{1'b1}})
        begin
            next = '0;
        end
        return next;
    endfunction

    function automatic wayIdxT lowestClearWay(input wayVecT bits);
        wayIdxT way;
        logic   found;
        way = '0;
        found = 1'b0;
        for (int w = 0; w < nWays; w++)
        begin
            if (!found && !bits[w])
            begin
                way = wayIdxT'(w);
                found = 1'b1;
            end
        end
        return way;
    endfunction

    // ====================
    // Checks
    // ====================

    // The sweep takes exactly nSets cycles and rdy never falls afterwards
    rdyTiming: assert property (@(posedge clk) resetb |-> (rdy == (sinceRelease >= nSets)))
        else flagMismatch("rdy", $sformatf("%b", $sampled(sinceRelease) >= nSets),
                          $sformatf("%b", $sampled(rdy)));

    missAnswered: assert property (@(posedge clk) disable iff (!resetb)
        (missEn && rdy) |=> victimValid)
        else reportFailure("victimValid did not come one cycle after an accepted miss");

    // Covers misses during the sweep as well as stray or stretched pulses
    noStrayVictim: assert property (@(posedge clk) disable iff (!resetb)
        !(missEn && rdy) |=> !victimValid)
        else reportFailure("victimValid was high without an accepted miss one cycle before");

    wayCheck: assert property (@(posedge clk) disable iff (!resetb)
        victimValid |-> (victimWay == expWay))
        else flagMismatch("victimWay", $sformatf("%0d", $sampled(expWay)),
                          $sformatf("%0d", $sampled(victimWay)));

    vecCheck: assert property (@(posedge clk) disable iff (!resetb)
        victimValid |-> (victimVec == expVec))
        else flagMismatch("victimVec", $sformatf("%b", $sampled(expVec)),
                          $sformatf("%b", $sampled(victimVec)));

    // ====================
    // Stimulus tasks
    // ====================

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // rdy is read on the falling edge where it is stable
    task automatic waitForReady();
        int count;
        count = 0;
        while (rdy !== 1'b1)
        begin
            if (count > 2 * nSets)
            begin
                reportFailure("rdy never rose after the initialization sweep");
            end
            @(negedge clk);
            count++;
        end
        @(posedge clk);
    endtask

    task automatic sendHit(input setIdxT set, input wayIdxT way);
        @(posedge clk);
        hitEn  <= 1'b1;
        hitIdx <= set;
        hitWay <= way;
        modelBits[set] = markWays(modelBits[set], oneHotOf(way));
        @(posedge clk);
        hitEn <= 1'b0;
        waitCycles(gapCycles);
    endtask

    // Two hits to one set on adjacent cycles, folded into one reference
    task automatic mergeHitPair(input setIdxT set, input wayIdxT wayA, input wayIdxT wayB);
        @(posedge clk);
        hitEn  <= 1'b1;
        hitIdx <= set;
        hitWay <= wayA;
        @(posedge clk);
        hitWay <= wayB;
        modelBits[set] = markWays(modelBits[set], oneHotOf(wayA) | oneHotOf(wayB));
        @(posedge clk);
        hitEn <= 1'b0;
        waitCycles(gapCycles);
    endtask

    task automatic issueMiss(input setIdxT set);
        wayIdxT way;
        way = lowestClearWay(modelBits[set]);
        @(posedge clk);
        missEn  <= 1'b1;
        missIdx <= set;
        expWay  <= way;
        expVec  <= oneHotOf(way);
        modelBits[set] = markWays(modelBits[set], oneHotOf(way));
        @(posedge clk);
        missEn <= 1'b0;
        waitCycles(gapCycles);
    endtask

    // A miss and a hit to a different set in the same cycle
    task automatic missBesideHit(input setIdxT mSet, input setIdxT hSet, input wayIdxT hWay);
        wayIdxT way;
        way = lowestClearWay(modelBits[mSet]);
        @(posedge clk);
        missEn  <= 1'b1;
        missIdx <= mSet;
        expWay  <= way;
        expVec  <= oneHotOf(way);
        hitEn   <= 1'b1;
        hitIdx  <= hSet;
        hitWay  <= hWay;
        modelBits[mSet] = markWays(modelBits[mSet], oneHotOf(way));
        modelBits[hSet] = markWays(modelBits[hSet], oneHotOf(hWay));
        @(posedge clk);
        missEn <= 1'b0;
        hitEn  <= 1'b0;
        waitCycles(gapCycles);
    endtask

    task automatic randomTraffic(input int count);
        logic [31:0] rnd;
        for (int i = 0; i < count; i++)
        begin
            rnd = $random(seed);
            sendHit(rnd[setIdxW-1:0], rnd[8 +: wayIdxW]);
            rnd = $random(seed);
            issueMiss(rnd[setIdxW-1:0]);
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial
    begin
        logic [31:0] rnd;
        resetb  = 1'b0;
        hitEn   = 1'b0;
        hitIdx  = '0;
        hitWay  = '0;
        missEn  = 1'b0;
        missIdx = '0;
        expWay  = '0;
        expVec  = '0;
        for (int s = 0; s < nSets; s++)
        begin
            modelBits[s] = '0;
        end

        testName = "initSweep";
        waitCycles(resetCycles);
        resetb <= 1'b1;
        waitCycles(10);
        // Miss while the sweep is still running must be ignored
        missEn  <= 1'b1;
        missIdx <= setIdxT'(3);
        @(posedge clk);
        missEn <= 1'b0;
        waitForReady();

        // Freshly cleared sets always give way 0, upper half only
        testName = "firstMiss";
        for (int i = 0; i < 8; i++)
        begin
            rnd = $random(seed);
            issueMiss({1'b1, rnd[setIdxW-2:0]});
        end

        testName = "spacedHits";
        sendHit(setIdxT'(7), wayIdxT'(0));
        sendHit(setIdxT'(7), wayIdxT'(1));
        sendHit(setIdxT'(7), wayIdxT'(3));
        issueMiss(setIdxT'(7));
        issueMiss(setIdxT'(7));

        // Four fills wrap the set, the fifth starts over at way 0
        testName = "missSequence";
        for (int i = 0; i < 5; i++)
        begin
            issueMiss(setIdxT'(12));
        end

        testName = "mergedHits";
        mergeHitPair(setIdxT'(20), wayIdxT'(1), wayIdxT'(2));
        issueMiss(setIdxT'(20));
        issueMiss(setIdxT'(20));

        testName = "missWithHit";
        missBesideHit(setIdxT'(9), setIdxT'(10), wayIdxT'(0));

        testName = "randomMix";
        randomTraffic(nRandom);

        waitCycles(4);
        $display(">>> PASS");
        $finish;
    end

    initial
    begin
        #(watchdogCycles * clkPeriod);
        reportFailure("Watchdog timeout, the stimulus did not finish in time");
    end

endmodule

`default_nettype wire

/* src.f */
hw/lruPkg.sv
hw/lruLookupIf.sv
hw/dualPortRam.sv
hw/hitRecorder.sv
hw/pseudoLru.sv
hw/victimSelector.sv
hw/lruTop.sv
sim/lruTopTb.sv
